// ==== Bender.yml ====
package:
  name: cpu

sources:
  - cpu_pkg.sv
  - alu_compute.sv
  - fetch_stage.sv
  - decode_stage.sv
  - hazard_unit.sv
  - execute_stage.sv
  - memory_stage.sv
  - cpu.sv
  - target: test
    files:
      - tb_cpu.sv

// ==== alu_compute.sv ====
`timescale 1ns/1ns

module alu_compute (
	input  logic [cpu_pkg::DATA_W-1:0] a_i,
	input  logic [cpu_pkg::DATA_W-1:0] b_i,
	input  logic [cpu_pkg::DATA_W-1:0] imm_i,
	input  logic [3:0]                 op_i,
	output logic [cpu_pkg::DATA_W-1:0] result_o,
	output logic [cpu_pkg::DATA_W-1:0] addr_o,
	output logic [2:0]                 flags_o
);

	logic [cpu_pkg::DATA_W-1:0]   sum;
	logic [cpu_pkg::DATA_W-1:0]   diff;
	logic                         sum_ovf;
	logic                         diff_ovf;
	logic [cpu_pkg::DATA_W-1:0]   red;
	logic [cpu_pkg::DATA_W-1:0]   paddsb;
	logic [4:0]                   lane;
	logic [2*cpu_pkg::DATA_W-1:0] ror_full;

	function automatic logic [15:0] sat16(input logic [15:0] raw, input logic ovf, input logic neg);
		if (!ovf) begin
			return raw;
		end
		return neg ? 16'h8000 : 16'h7fff;
	endfunction

	assign sum      = a_i + b_i;
	assign diff     = a_i - b_i;
	assign sum_ovf  = a_i[15] == b_i[15] && sum[15] != a_i[15];
	assign diff_ovf = a_i[15] != b_i[15] && diff[15] != a_i[15];

	assign red = {{8{a_i[7]}}, a_i[7:0]} + {{8{a_i[15]}}, a_i[15:8]} +
		{{8{b_i[7]}}, b_i[7:0]} + {{8{b_i[15]}}, b_i[15:8]};

	// each nibble saturates on its own
	always_comb begin
		lane = '0;
		for (int i = 0; i < 4; i++) begin
			lane = {a_i[4*i+3], a_i[4*i +: 4]} + {b_i[4*i+3], b_i[4*i +: 4]};
			paddsb[4*i +: 4] = (lane[4] != lane[3]) ? (lane[4] ? 4'h8 : 4'h7) : lane[3:0];
		end
	end

	assign ror_full = {a_i, a_i} >> imm_i[3:0];
	// word aligned base plus the offset scaled to bytes
	assign addr_o   = {a_i[15:1], 1'b0} + {imm_i[14:0], 1'b0};

	always_comb begin
		case (op_i)
			cpu_pkg::OP_ADD:    result_o = sat16(sum, sum_ovf, a_i[15]);
			cpu_pkg::OP_SUB:    result_o = sat16(diff, diff_ovf, a_i[15]);
			cpu_pkg::OP_RED:    result_o = red;
			cpu_pkg::OP_XOR:    result_o = a_i ^ b_i;
			cpu_pkg::OP_SLL:    result_o = a_i << imm_i[3:0];
			cpu_pkg::OP_SRA:    result_o = $signed(a_i) >>> imm_i[3:0];
			cpu_pkg::OP_ROR:    result_o = ror_full[15:0];
			cpu_pkg::OP_PADDSB: result_o = paddsb;
			cpu_pkg::OP_LW,
			cpu_pkg::OP_SW:     result_o = addr_o;
			cpu_pkg::OP_LLB:    result_o = {a_i[15:8], imm_i[7:0]};
			cpu_pkg::OP_LHB:    result_o = {imm_i[7:0], a_i[7:0]};
			default:            result_o = a_i;
		endcase
		flags_o[cpu_pkg::FLAG_Z] = result_o == '0;
		flags_o[cpu_pkg::FLAG_N] = result_o[15];
		flags_o[cpu_pkg::FLAG_V] = (op_i == cpu_pkg::OP_ADD && sum_ovf) ||
			(op_i == cpu_pkg::OP_SUB && diff_ovf);
	end

endmodule

// ==== build.f ====
cpu_pkg.sv
alu_compute.sv
fetch_stage.sv
decode_stage.sv
hazard_unit.sv
execute_stage.sv
memory_stage.sv
cpu.sv
tb_cpu.sv

// ==== cpu.sv ====
`timescale 1ns/1ns

module cpu (
	input  logic                        clk_i,
	input  logic                        arst_n_i,
	input  logic                        imem_we_i,
	input  logic [cpu_pkg::IMEM_AW-1:0] imem_addr_i,
	input  logic [cpu_pkg::DATA_W-1:0]  imem_wdata_i,
	output logic [cpu_pkg::DATA_W-1:0]  pc_o,
	output logic                        hlt_o,
	output logic                        wb_en_o,
	output logic [cpu_pkg::REG_AW-1:0]  wb_reg_o,
	output logic [cpu_pkg::DATA_W-1:0]  wb_data_o
);

	logic [cpu_pkg::DATA_W-1:0] ifid_instr, ifid_pc_plus2;
	logic [cpu_pkg::REG_AW-1:0] if_rs, if_rt;
	logic                       stall;
	logic [3:0]                 id_op;
	logic [cpu_pkg::REG_AW-1:0] id_rd, id_rs, id_rt;
	logic [cpu_pkg::DATA_W-1:0] id_a, id_b, id_imm, id_pc_plus2;
	logic [2:0]                 id_ccode;
	logic [1:0]                 fwd_a, fwd_b;
	logic                       br_taken;
	logic [cpu_pkg::DATA_W-1:0] br_target;
	logic [3:0]                 ex_op, wb_op;
	logic [cpu_pkg::REG_AW-1:0] ex_rd;
	logic [cpu_pkg::DATA_W-1:0] ex_result, ex_store_data, ex_addr, mem_fwd_data;

	assign if_rs = cpu_pkg::src_rs(ifid_instr);
	assign if_rt = cpu_pkg::src_rt(ifid_instr);

	fetch_stage u_fetch (
		.clk_i, .arst_n_i, .stall_i(stall), .br_taken_i(br_taken), .br_target_i(br_target),
		.imem_we_i, .imem_addr_i, .imem_wdata_i,
		.instr_o(ifid_instr), .pc_plus2_o(ifid_pc_plus2), .pc_o
	);

	decode_stage u_decode (
		.clk_i, .arst_n_i, .stall_i(stall), .flush_i(br_taken),
		.instr_i(ifid_instr), .pc_plus2_i(ifid_pc_plus2),
		.wb_en_i(wb_en_o), .wb_reg_i(wb_reg_o), .wb_data_i(wb_data_o),
		.op_o(id_op), .rd_o(id_rd), .rs_o(id_rs), .rt_o(id_rt), .a_o(id_a), .b_o(id_b),
		.imm_o(id_imm), .ccode_o(id_ccode), .pc_plus2_o(id_pc_plus2)
	);

	hazard_unit u_hazard (
		.id_op_i(id_op), .id_rd_i(id_rd), .if_rs_i(if_rs), .if_rt_i(if_rt),
		.ex_rs_i(id_rs), .ex_rt_i(id_rt), .mem_op_i(ex_op), .mem_rd_i(ex_rd),
		.wb_op_i(wb_op), .wb_rd_i(wb_reg_o),
		.stall_o(stall), .fwd_a_o(fwd_a), .fwd_b_o(fwd_b)
	);

	execute_stage u_execute (
		.clk_i, .arst_n_i, .op_i(id_op), .rd_i(id_rd), .a_i(id_a), .b_i(id_b),
		.imm_i(id_imm), .ccode_i(id_ccode), .pc_plus2_i(id_pc_plus2),
		.fwd_a_i(fwd_a), .fwd_b_i(fwd_b), .mem_fwd_i(mem_fwd_data), .wb_fwd_i(wb_data_o),
		.br_taken_o(br_taken), .br_target_o(br_target), .op_o(ex_op), .rd_o(ex_rd),
		.result_o(ex_result), .store_data_o(ex_store_data), .addr_o(ex_addr)
	);

	memory_stage u_memory (
		.clk_i, .arst_n_i, .op_i(ex_op), .rd_i(ex_rd), .result_i(ex_result),
		.store_data_i(ex_store_data), .addr_i(ex_addr), .mem_fwd_o(mem_fwd_data),
		.wb_en_o, .wb_reg_o, .wb_data_o, .wb_op_o(wb_op), .hlt_o
	);

endmodule

// ==== cpu_pkg.sv ====
package cpu_pkg;

	localparam int DATA_W  = 16;
	localparam int REG_AW  = 4;
	localparam int IMEM_AW = 8;
	localparam int DMEM_AW = 8;

	// opcode sits in the top nibble of every instruction
	localparam logic [3:0] OP_ADD    = 4'b0000;
	localparam logic [3:0] OP_SUB    = 4'b0001;
	localparam logic [3:0] OP_RED    = 4'b0010;
	localparam logic [3:0] OP_XOR    = 4'b0011;
	localparam logic [3:0] OP_SLL    = 4'b0100;
	localparam logic [3:0] OP_SRA    = 4'b0101;
	localparam logic [3:0] OP_ROR    = 4'b0110;
	localparam logic [3:0] OP_PADDSB = 4'b0111;
	localparam logic [3:0] OP_LW     = 4'b1000;
	localparam logic [3:0] OP_SW     = 4'b1001;
	localparam logic [3:0] OP_LHB    = 4'b1010;
	localparam logic [3:0] OP_LLB    = 4'b1011;
	localparam logic [3:0] OP_B      = 4'b1100;
	localparam logic [3:0] OP_BR     = 4'b1101;
	localparam logic [3:0] OP_PCS    = 4'b1110;
	localparam logic [3:0] OP_HLT    = 4'b1111;

	localparam logic [2:0] CC_NE = 3'b000;
	localparam logic [2:0] CC_EQ = 3'b001;
	localparam logic [2:0] CC_GT = 3'b010;
	localparam logic [2:0] CC_LT = 3'b011;
	localparam logic [2:0] CC_GE = 3'b100;
	localparam logic [2:0] CC_LE = 3'b101;
	localparam logic [2:0] CC_OV = 3'b110;
	localparam logic [2:0] CC_UN = 3'b111;

	localparam logic [1:0] FWD_NONE = 2'b00;
	localparam logic [1:0] FWD_WB   = 2'b01;
	localparam logic [1:0] FWD_MEM  = 2'b10;

	localparam int FLAG_Z = 0;
	localparam int FLAG_V = 1;
	localparam int FLAG_N = 2;

	// RED r0,r0,r0 has no effect at all, so it fills IF/ID when it is empty
	localparam logic [DATA_W-1:0] NOP_INSTR = 16'h2000;
	// a real ADD to r0 always carries ccode 000, so this marks an ID/EX bubble
	localparam logic [2:0] BUBBLE_CC = CC_UN;

	function automatic logic writes_reg(input logic [3:0] op);
		return !(op == OP_SW || op == OP_B || op == OP_BR || op == OP_HLT);
	endfunction

	// LLB and LHB read the old value of rd through the rs port
	function automatic logic [REG_AW-1:0] src_rs(input logic [DATA_W-1:0] instr);
		if (instr[15:12] == OP_LLB || instr[15:12] == OP_LHB) begin
			return instr[11:8];
		end
		return instr[7:4];
	endfunction

	function automatic logic [REG_AW-1:0] src_rt(input logic [DATA_W-1:0] instr);
		if (instr[15:12] == OP_LW || instr[15:12] == OP_SW) begin
			return instr[11:8];
		end
		return instr[3:0];
	endfunction

endpackage

// ==== decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
	input  logic                         clk_i,
	input  logic                         arst_n_i,
	input  logic                         stall_i,
	input  logic                         flush_i,
	input  logic [cpu_pkg::DATA_W-1:0]   instr_i,
	input  logic [cpu_pkg::DATA_W-1:0]   pc_plus2_i,
	input  logic                         wb_en_i,
	input  logic [cpu_pkg::REG_AW-1:0]   wb_reg_i,
	input  logic [cpu_pkg::DATA_W-1:0]   wb_data_i,
	output logic [3:0]                   op_o,
	output logic [cpu_pkg::REG_AW-1:0]   rd_o,
	output logic [cpu_pkg::REG_AW-1:0]   rs_o,
	output logic [cpu_pkg::REG_AW-1:0]   rt_o,
	output logic [cpu_pkg::DATA_W-1:0]   a_o,
	output logic [cpu_pkg::DATA_W-1:0]   b_o,
	output logic [cpu_pkg::DATA_W-1:0]   imm_o,
	output logic [2:0]                   ccode_o,
	output logic [cpu_pkg::DATA_W-1:0]   pc_plus2_o
);

	logic [cpu_pkg::DATA_W-1:0] rf [2**cpu_pkg::REG_AW];
	logic [3:0]                 op;
	logic [cpu_pkg::REG_AW-1:0] rs;
	logic [cpu_pkg::REG_AW-1:0] rt;
	logic [cpu_pkg::DATA_W-1:0] imm;
	logic                       bubble;

	assign op     = instr_i[15:12];
	assign rs     = cpu_pkg::src_rs(instr_i);
	assign rt     = cpu_pkg::src_rt(instr_i);
	assign bubble = stall_i || flush_i;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < 2**cpu_pkg::REG_AW; i++) begin
				rf[i] <= '0;
			end
		end else if (wb_en_i && wb_reg_i != '0) begin
			rf[wb_reg_i] <= wb_data_i;
		end
	end

	// a write in this cycle is passed straight to the read ports
	function automatic logic [cpu_pkg::DATA_W-1:0] read_reg(input logic [cpu_pkg::REG_AW-1:0] idx);
		if (idx == '0) begin
			return '0;
		end
		if (wb_en_i && wb_reg_i == idx) begin
			return wb_data_i;
		end
		return rf[idx];
	endfunction

	always_comb begin
		case (op)
			cpu_pkg::OP_LLB, cpu_pkg::OP_LHB: imm = {8'h00, instr_i[7:0]};
			cpu_pkg::OP_B:                    imm = {{7{instr_i[8]}}, instr_i[8:0]};
			default:                          imm = {{12{instr_i[3]}}, instr_i[3:0]};
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			op_o    <= cpu_pkg::OP_ADD;
			rd_o    <= '0;
			rs_o    <= '0;
			rt_o    <= '0;
			ccode_o <= cpu_pkg::BUBBLE_CC;
		end else begin
			op_o    <= bubble ? cpu_pkg::OP_ADD : op;
			rd_o    <= bubble ? '0 : instr_i[11:8];
			rs_o    <= bubble ? '0 : rs;
			rt_o    <= bubble ? '0 : rt;
			ccode_o <= bubble ? cpu_pkg::BUBBLE_CC : instr_i[11:9];
		end
	end

	always_ff @(posedge clk_i) begin
		a_o        <= read_reg(rs);
		b_o        <= read_reg(rt);
		imm_o      <= imm;
		pc_plus2_o <= pc_plus2_i;
	end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
	input  logic                       clk_i,
	input  logic                       arst_n_i,
	input  logic [3:0]                 op_i,
	input  logic [cpu_pkg::REG_AW-1:0] rd_i,
	input  logic [cpu_pkg::DATA_W-1:0] a_i,
	input  logic [cpu_pkg::DATA_W-1:0] b_i,
	input  logic [cpu_pkg::DATA_W-1:0] imm_i,
	input  logic [2:0]                 ccode_i,
	input  logic [cpu_pkg::DATA_W-1:0] pc_plus2_i,
	input  logic [1:0]                 fwd_a_i,
	input  logic [1:0]                 fwd_b_i,
	input  logic [cpu_pkg::DATA_W-1:0] mem_fwd_i,
	input  logic [cpu_pkg::DATA_W-1:0] wb_fwd_i,
	output logic                       br_taken_o,
	output logic [cpu_pkg::DATA_W-1:0] br_target_o,
	output logic [3:0]                 op_o,
	output logic [cpu_pkg::REG_AW-1:0] rd_o,
	output logic [cpu_pkg::DATA_W-1:0] result_o,
	output logic [cpu_pkg::DATA_W-1:0] store_data_o,
	output logic [cpu_pkg::DATA_W-1:0] addr_o
);

	logic [cpu_pkg::DATA_W-1:0] a_fwd;
	logic [cpu_pkg::DATA_W-1:0] b_fwd;
	logic [cpu_pkg::DATA_W-1:0] alu_result;
	logic [cpu_pkg::DATA_W-1:0] alu_addr;
	logic [2:0]                 alu_flags;
	logic [2:0]                 flags_q;
	logic [2:0]                 flag_we;
	logic                       bubble;
	logic                       cond_ok;
	logic                       z, v, n;

	function automatic logic [15:0] fwd_mux(input logic [1:0] sel, input logic [15:0] reg_val);
		case (sel)
			cpu_pkg::FWD_MEM: return mem_fwd_i;
			cpu_pkg::FWD_WB:  return wb_fwd_i;
			default:          return reg_val;
		endcase
	endfunction

	always_comb begin
		a_fwd = fwd_mux(fwd_a_i, a_i);
		b_fwd = fwd_mux(fwd_b_i, b_i);
	end

	alu_compute u_alu (
		.a_i      (a_fwd),
		.b_i      (b_fwd),
		.imm_i    (imm_i),
		.op_i     (op_i),
		.result_o (alu_result),
		.addr_o   (alu_addr),
		.flags_o  (alu_flags)
	);

	assign bubble = op_i == cpu_pkg::OP_ADD && rd_i == '0 && ccode_i == cpu_pkg::BUBBLE_CC;

	always_comb begin
		flag_we = '0;
		case (op_i)
			cpu_pkg::OP_ADD, cpu_pkg::OP_SUB: flag_we = bubble ? 3'b000 : 3'b111;
			cpu_pkg::OP_XOR, cpu_pkg::OP_SLL,
			cpu_pkg::OP_SRA, cpu_pkg::OP_ROR: flag_we[cpu_pkg::FLAG_Z] = 1'b1;
			default: flag_we = '0;
		endcase
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			flags_q <= '0;
		end else begin
			flags_q <= (flag_we & alu_flags) | (~flag_we & flags_q);
		end
	end

	assign z = flags_q[cpu_pkg::FLAG_Z];
	assign v = flags_q[cpu_pkg::FLAG_V];
	assign n = flags_q[cpu_pkg::FLAG_N];

	always_comb begin
		case (ccode_i)
			cpu_pkg::CC_NE: cond_ok = !z;
			cpu_pkg::CC_EQ: cond_ok = z;
			cpu_pkg::CC_GT: cond_ok = !z && !n;
			cpu_pkg::CC_LT: cond_ok = n;
			cpu_pkg::CC_GE: cond_ok = z || !n;
			cpu_pkg::CC_LE: cond_ok = z || n;
			cpu_pkg::CC_OV: cond_ok = v;
			default:        cond_ok = 1'b1;
		endcase
	end

	assign br_taken_o  = (op_i == cpu_pkg::OP_B || op_i == cpu_pkg::OP_BR) && cond_ok;
	// register targets drop bit 0 so fetch stays aligned
	assign br_target_o = (op_i == cpu_pkg::OP_BR) ? {a_fwd[15:1], 1'b0} :
		pc_plus2_i + {imm_i[14:0], 1'b0};

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			op_o <= cpu_pkg::OP_ADD;
			rd_o <= '0;
		end else begin
			op_o <= op_i;
			rd_o <= rd_i;
		end
	end

	always_ff @(posedge clk_i) begin
		result_o     <= (op_i == cpu_pkg::OP_PCS) ? pc_plus2_i : alu_result;
		store_data_o <= b_fwd;
		addr_o       <= alu_addr;
	end

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage (
	input  logic                         clk_i,
	input  logic                         arst_n_i,
	input  logic                         stall_i,
	input  logic                         br_taken_i,
	input  logic [cpu_pkg::DATA_W-1:0]   br_target_i,
	input  logic                         imem_we_i,
	input  logic [cpu_pkg::IMEM_AW-1:0]  imem_addr_i,
	input  logic [cpu_pkg::DATA_W-1:0]   imem_wdata_i,
	output logic [cpu_pkg::DATA_W-1:0]   instr_o,
	output logic [cpu_pkg::DATA_W-1:0]   pc_plus2_o,
	output logic [cpu_pkg::DATA_W-1:0]   pc_o
);

	logic [cpu_pkg::DATA_W-1:0] imem [2**cpu_pkg::IMEM_AW];
	logic [cpu_pkg::DATA_W-1:0] pc_q;
	logic [cpu_pkg::DATA_W-1:0] pc_next;
	logic [cpu_pkg::DATA_W-1:0] pc_plus2;
	logic [cpu_pkg::DATA_W-1:0] fetched;

	always_ff @(posedge clk_i) begin
		if (imem_we_i) begin
			imem[imem_addr_i] <= imem_wdata_i;
		end
	end

	assign fetched  = imem[pc_q[cpu_pkg::IMEM_AW:1]];
	assign pc_plus2 = pc_q + 16'd2;

	// a halt freezes the PC as soon as it is read, unless an older branch redirects
	always_comb begin
		if (br_taken_i) begin
			pc_next = br_target_i;
		end else if (stall_i || fetched[15:12] == cpu_pkg::OP_HLT) begin
			pc_next = pc_q;
		end else begin
			pc_next = pc_plus2;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q       <= '0;
			instr_o    <= cpu_pkg::NOP_INSTR;
			pc_plus2_o <= '0;
		end else begin
			pc_q <= pc_next;
			if (br_taken_i) begin
				instr_o <= cpu_pkg::NOP_INSTR;
			end else if (!stall_i) begin
				instr_o    <= fetched;
				pc_plus2_o <= pc_plus2;
			end
		end
	end

	assign pc_o = pc_q;

	// branch targets from execute must keep the PC on a word boundary
	assert property (@(posedge clk_i) disable iff (!arst_n_i) pc_q[0] == 1'b0)
		else $error("PC became odd: %h", pc_q);

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit (
	input  logic [3:0]                 id_op_i,
	input  logic [cpu_pkg::REG_AW-1:0] id_rd_i,
	input  logic [cpu_pkg::REG_AW-1:0] if_rs_i,
	input  logic [cpu_pkg::REG_AW-1:0] if_rt_i,
	input  logic [cpu_pkg::REG_AW-1:0] ex_rs_i,
	input  logic [cpu_pkg::REG_AW-1:0] ex_rt_i,
	input  logic [3:0]                 mem_op_i,
	input  logic [cpu_pkg::REG_AW-1:0] mem_rd_i,
	input  logic [3:0]                 wb_op_i,
	input  logic [cpu_pkg::REG_AW-1:0] wb_rd_i,
	output logic                       stall_o,
	output logic [1:0]                 fwd_a_o,
	output logic [1:0]                 fwd_b_o
);

	// the younger result in EX/MEM wins over MEM/WB
	function automatic logic [1:0] fwd_sel(input logic [cpu_pkg::REG_AW-1:0] src);
		if (src != '0 && cpu_pkg::writes_reg(mem_op_i) && mem_rd_i == src) begin
			return cpu_pkg::FWD_MEM;
		end
		if (src != '0 && cpu_pkg::writes_reg(wb_op_i) && wb_rd_i == src) begin
			return cpu_pkg::FWD_WB;
		end
		return cpu_pkg::FWD_NONE;
	endfunction

	always_comb begin
		fwd_a_o = fwd_sel(ex_rs_i);
		fwd_b_o = fwd_sel(ex_rt_i);
	end

	// load data is only ready in MEM/WB, so a direct consumer waits one cycle
	assign stall_o = id_op_i == cpu_pkg::OP_LW && id_rd_i != '0 &&
		(id_rd_i == if_rs_i || id_rd_i == if_rt_i);

	// EX/MEM of a load still holds its address, so the stall must keep consumers away
	always_comb begin
		assert final (!((fwd_a_o == cpu_pkg::FWD_MEM || fwd_b_o == cpu_pkg::FWD_MEM) &&
			mem_op_i == cpu_pkg::OP_LW))
			else $error("operand forwarded from a load still in EX/MEM");
	end

endmodule

// ==== memory_stage.sv ====
`timescale 1ns/1ns

module memory_stage (
	input  logic                       clk_i,
	input  logic                       arst_n_i,
	input  logic [3:0]                 op_i,
	input  logic [cpu_pkg::REG_AW-1:0] rd_i,
	input  logic [cpu_pkg::DATA_W-1:0] result_i,
	input  logic [cpu_pkg::DATA_W-1:0] store_data_i,
	input  logic [cpu_pkg::DATA_W-1:0] addr_i,
	output logic [cpu_pkg::DATA_W-1:0] mem_fwd_o,
	output logic                       wb_en_o,
	output logic [cpu_pkg::REG_AW-1:0] wb_reg_o,
	output logic [cpu_pkg::DATA_W-1:0] wb_data_o,
	output logic [3:0]                 wb_op_o,
	output logic                       hlt_o
);

	logic [cpu_pkg::DATA_W-1:0]  dmem [2**cpu_pkg::DMEM_AW];
	logic [cpu_pkg::DMEM_AW-1:0] word_addr;

	assign word_addr = addr_i[cpu_pkg::DMEM_AW:1];
	assign mem_fwd_o = result_i;

	always_ff @(posedge clk_i) begin
		if (op_i == cpu_pkg::OP_SW) begin
			dmem[word_addr] <= store_data_i;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_op_o  <= cpu_pkg::OP_ADD;
			wb_reg_o <= '0;
			hlt_o    <= 1'b0;
		end else begin
			wb_op_o  <= op_i;
			wb_reg_o <= rd_i;
			// stays set until the next reset
			hlt_o    <= hlt_o || op_i == cpu_pkg::OP_HLT;
		end
	end

	always_ff @(posedge clk_i) begin
		wb_data_o <= (op_i == cpu_pkg::OP_LW) ? dmem[word_addr] : result_i;
	end

	// writes to r0 and bubbles never show on the write-back bus
	assign wb_en_o = cpu_pkg::writes_reg(wb_op_o) && wb_reg_o != '0;

	assert property (@(posedge clk_i) disable iff (!arst_n_i) hlt_o |-> !wb_en_o)
		else $error("register write after halt retired");

endmodule

// ==== tb_cpu.sv ====
`timescale 1ns/1ns

module tb_cpu;

	localparam int          WAIT_LIMIT = 2000;
	localparam logic [31:0] SEED       = 32'h7e019214;

	logic                        clk = 1'b0;
	logic                        arst_n;
	logic                        imem_we;
	logic [cpu_pkg::IMEM_AW-1:0] imem_addr;
	logic [cpu_pkg::DATA_W-1:0]  imem_wdata;
	logic [cpu_pkg::DATA_W-1:0]  pc_o;
	logic                        hlt_o;
	logic                        wb_en_o;
	logic [cpu_pkg::REG_AW-1:0]  wb_reg_o;
	logic [cpu_pkg::DATA_W-1:0]  wb_data_o;

	logic [15:0] prog [256];
	int          prog_len;
	// data memory as the model sees it, kept across programs like the DUT's
	logic [15:0] model_mem [256];
	logic [3:0]  exp_reg [$];
	logic [15:0] exp_data [$];
	int          got;
	int          errors;
	int          checks;
	logic [31:0] rng_state;
	string       test_name;

	cpu DUT (
		.clk_i        (clk),
		.arst_n_i     (arst_n),
		.imem_we_i    (imem_we),
		.imem_addr_i  (imem_addr),
		.imem_wdata_i (imem_wdata),
		.pc_o         (pc_o),
		.hlt_o        (hlt_o),
		.wb_en_o      (wb_en_o),
		.wb_reg_o     (wb_reg_o),
		.wb_data_o    (wb_data_o)
	);

	always #50 clk = ~clk;

	task automatic check_value(input string what, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [15:0] enc_rrr(input logic [3:0] op, input logic [3:0] rd,
		input logic [3:0] rs, input logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic logic [15:0] enc_imm8(input logic [3:0] op, input logic [3:0] rd,
		input logic [7:0] imm8);
		return {op, rd, imm8};
	endfunction

	function automatic logic [15:0] enc_branch(input logic [2:0] cc, input logic [8:0] off);
		return {cpu_pkg::OP_B, cc, off};
	endfunction

	function automatic logic cond_holds(input logic [2:0] cc, input logic z, input logic v,
		input logic n);
		case (cc)
			cpu_pkg::CC_NE: return !z;
			cpu_pkg::CC_EQ: return z;
			cpu_pkg::CC_GT: return !z && !n;
			cpu_pkg::CC_LT: return n;
			cpu_pkg::CC_GE: return z || !n;
			cpu_pkg::CC_LE: return z || n;
			cpu_pkg::CC_OV: return v;
			default:        return 1'b1;
		endcase
	endfunction

	// sequential model that fills the expected write list and returns the HLT address
	function automatic logic [15:0] run_model(input int len);
		logic [15:0] r [16];
		logic        z, v, n;
		logic [15:0] pc, ins, a, b, res, addr;
		logic [3:0]  op, rd;
		logic        wr;
		int          sa, sb, s, t;
		exp_reg.delete();
		exp_data.delete();
		for (int i = 0; i < 16; i++) begin
			r[i] = 16'h0000;
		end
		z = 1'b0;
		v = 1'b0;
		n = 1'b0;
		pc = 16'h0000;
		for (int step = 0; step < 4096; step++) begin
			if ((pc >> 1) >= len) begin
				return 16'hffff;
			end
			ins = prog[pc[8:1]];
			op = ins[15:12];
			rd = ins[11:8];
			if (op == cpu_pkg::OP_HLT) begin
				return pc;
			end
			a = r[ins[7:4]];
			b = r[ins[3:0]];
			sa = $signed(a);
			sb = $signed(b);
			res = 16'h0000;
			wr = 1'b1;
			addr = {a[15:1], 1'b0} + {{11{ins[3]}}, ins[3:0], 1'b0};
			pc = pc + 16'd2;
			case (op)
				cpu_pkg::OP_ADD, cpu_pkg::OP_SUB: begin
					s = (op == cpu_pkg::OP_ADD) ? sa + sb : sa - sb;
					v = 1'b0;
					if (s > 32767) begin
						s = 32767;
						v = 1'b1;
					end else if (s < -32768) begin
						s = -32768;
						v = 1'b1;
					end
					res = s[15:0];
					z = res == 16'h0000;
					n = res[15];
				end
				cpu_pkg::OP_RED: begin
					s = 0;
					for (int k = 0; k < 2; k++) begin
						s += $signed(a[8*k +: 8]) + $signed(b[8*k +: 8]);
					end
					res = s[15:0];
				end
				cpu_pkg::OP_PADDSB: begin
					for (int k = 0; k < 4; k++) begin
						t = $signed(a[4*k +: 4]) + $signed(b[4*k +: 4]);
						if (t > 7) t = 7;
						if (t < -8) t = -8;
						res[4*k +: 4] = t[3:0];
					end
				end
				cpu_pkg::OP_XOR: res = a ^ b;
				cpu_pkg::OP_SLL: res = a << ins[3:0];
				cpu_pkg::OP_SRA: res = $signed(a) >>> ins[3:0];
				cpu_pkg::OP_ROR: begin
					res = a;
					for (int k = 0; k < ins[3:0]; k++) begin
						res = {res[0], res[15:1]};
					end
				end
				cpu_pkg::OP_LW:  res = model_mem[addr[8:1]];
				cpu_pkg::OP_SW: begin
					model_mem[addr[8:1]] = r[rd];
					wr = 1'b0;
				end
				cpu_pkg::OP_LLB: res = {r[rd][15:8], ins[7:0]};
				cpu_pkg::OP_LHB: res = {ins[7:0], r[rd][7:0]};
				cpu_pkg::OP_B: begin
					wr = 1'b0;
					if (cond_holds(ins[11:9], z, v, n)) begin
						pc = pc + {{6{ins[8]}}, ins[8:0], 1'b0};
					end
				end
				cpu_pkg::OP_BR: begin
					wr = 1'b0;
					if (cond_holds(ins[11:9], z, v, n)) begin
						pc = {a[15:1], 1'b0};
					end
				end
				default: res = pc;
			endcase
			// only XOR and the shifts touch Z alone
			if (op == cpu_pkg::OP_XOR || op == cpu_pkg::OP_SLL ||
				op == cpu_pkg::OP_SRA || op == cpu_pkg::OP_ROR) begin
				z = res == 16'h0000;
			end
			if (wr && rd != 4'd0) begin
				r[rd] = res;
				exp_reg.push_back(rd);
				exp_data.push_back(res);
			end
		end
		return 16'hffff;
	endfunction

	task automatic append_instr(input logic [15:0] w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	// the sixteen words reachable from r0 get a known value before any random load
	task automatic build_dmem_clear();
		prog_len = 0;
		for (int i = 0; i < 16; i++) begin
			append_instr(enc_rrr(cpu_pkg::OP_SW, 4'd0, 4'd0, 4'(i)));
		end
		append_instr(enc_rrr(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
	endtask

	task automatic build_alu_program();
		prog_len = 0;
		append_instr(enc_imm8(cpu_pkg::OP_LLB, 4'd1, 8'hff));
		append_instr(enc_imm8(cpu_pkg::OP_LHB, 4'd1, 8'h7f));
		append_instr(enc_imm8(cpu_pkg::OP_LLB, 4'd2, 8'h01));
		append_instr(enc_rrr(cpu_pkg::OP_ADD, 4'd3, 4'd1, 4'd2));
		append_instr(enc_rrr(cpu_pkg::OP_SUB, 4'd4, 4'd0, 4'd3));
		append_instr(enc_rrr(cpu_pkg::OP_SUB, 4'd5, 4'd4, 4'd2));
		append_instr(enc_rrr(cpu_pkg::OP_SUB, 4'd5, 4'd5, 4'd2));
		append_instr(enc_rrr(cpu_pkg::OP_XOR, 4'd6, 4'd5, 4'd3));
		append_instr(enc_rrr(cpu_pkg::OP_SLL, 4'd7, 4'd6, 4'd4));
		append_instr(enc_rrr(cpu_pkg::OP_SRA, 4'd8, 4'd7, 4'd3));
		append_instr(enc_rrr(cpu_pkg::OP_ROR, 4'd9, 4'd3, 4'd5));
		append_instr(enc_imm8(cpu_pkg::OP_LLB, 4'd10, 8'h7f));
		append_instr(enc_imm8(cpu_pkg::OP_LHB, 4'd10, 8'h80));
		append_instr(enc_rrr(cpu_pkg::OP_RED, 4'd11, 4'd10, 4'd1));
		append_instr(enc_rrr(cpu_pkg::OP_PADDSB, 4'd12, 4'd10, 4'd1));
		append_instr(enc_rrr(cpu_pkg::OP_PADDSB, 4'd13, 4'd6, 4'd6));
		append_instr(enc_rrr(cpu_pkg::OP_ADD, 4'd14, 4'd12, 4'd11));
		append_instr(enc_rrr(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
	endtask

	task automatic build_load_store_program();
		prog_len = 0;
		append_instr(enc_imm8(cpu_pkg::OP_LLB, 4'd1, 8'h34));
		append_instr(enc_imm8(cpu_pkg::OP_LHB, 4'd1, 8'h12));
		append_instr(enc_imm8(cpu_pkg::OP_LLB, 4'd2, 8'h20));
		append_instr(enc_rrr(cpu_pkg::OP_SW, 4'd1, 4'd2, 4'd3));
		append_instr(enc_rrr(cpu_pkg::OP_LW, 4'd3, 4'd2, 4'd3));
		append_instr(enc_rrr(cpu_pkg::OP_ADD, 4'd4, 4'd3, 4'd1));
		append_instr(enc_rrr(cpu_pkg::OP_LW, 4'd5, 4'd2, 4'd3));
		append_instr(enc_rrr(cpu_pkg::OP_SW, 4'd5, 4'd2, 4'hf));
		append_instr(enc_rrr(cpu_pkg::OP_LW, 4'd6, 4'd2, 4'hf));
		append_instr(enc_imm8(cpu_pkg::OP_LLB, 4'd6, 8'h99));
		append_instr(enc_rrr(cpu_pkg::OP_XOR, 4'd7, 4'd6, 4'd4));
		append_instr(enc_rrr(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
	endtask

	// every skipped instruction writes r15, so a wrong-path write shows up at once
	task automatic build_branch_program();
		prog_len = 0;
		append_instr(enc_imm8(cpu_pkg::OP_LLB, 4'd1, 8'h01));
		append_instr(enc_rrr(cpu_pkg::OP_SUB, 4'd2, 4'd1, 4'd1));
		append_instr(enc_branch(cpu_pkg::CC_NE, 9'd1));
		append_instr(enc_branch(cpu_pkg::CC_EQ, 9'd1));
		append_instr(enc_imm8(cpu_pkg::OP_LLB, 4'd15, 8'h11));
		append_instr(enc_rrr(cpu_pkg::OP_SUB, 4'd3, 4'd0, 4'd1));
		append_instr(enc_branch(cpu_pkg::CC_LT, 9'd1));
		append_instr(enc_imm8(cpu_pkg::OP_LLB, 4'd15, 8'h22));
		append_instr(enc_branch(cpu_pkg::CC_GT, 9'd1));
		append_instr(enc_branch(cpu_pkg::CC_LE, 9'd1));
		append_instr(enc_imm8(cpu_pkg::OP_LLB, 4'd15, 8'h33));
		append_instr(enc_branch(cpu_pkg::CC_GE, 9'd1));
		append_instr(enc_rrr(cpu_pkg::OP_ADD, 4'd4, 4'd1, 4'd1));
		append_instr(enc_branch(cpu_pkg::CC_GT, 9'd1));
		append_instr(enc_imm8(cpu_pkg::OP_LLB, 4'd15, 8'h44));
		append_instr(enc_branch(cpu_pkg::CC_GE, 9'd1));
		append_instr(enc_imm8(cpu_pkg::OP_LLB, 4'd15, 8'h55));
		append_instr(enc_branch(cpu_pkg::CC_OV, 9'd1));
		append_instr(enc_imm8(cpu_pkg::OP_LLB, 4'd5, 8'h00));
		append_instr(enc_imm8(cpu_pkg::OP_LHB, 4'd5, 8'h80));
		append_instr(enc_rrr(cpu_pkg::OP_ADD, 4'd6, 4'd5, 4'd5));
		append_instr(enc_branch(cpu_pkg::CC_OV, 9'd1));
		append_instr(enc_imm8(cpu_pkg::OP_LLB, 4'd15, 8'h66));
		append_instr(enc_branch(cpu_pkg::CC_UN, 9'd1));
		append_instr(enc_imm8(cpu_pkg::OP_LLB, 4'd15, 8'h77));
		append_instr(enc_rrr(cpu_pkg::OP_PCS, 4'd7, 4'd0, 4'd0));
		// word 29 sits at byte address 0x3a
		append_instr(enc_imm8(cpu_pkg::OP_LLB, 4'd8, 8'h3a));
		append_instr(enc_rrr(cpu_pkg::OP_BR, {cpu_pkg::CC_UN, 1'b0}, 4'd8, 4'd0));
		append_instr(enc_imm8(cpu_pkg::OP_LLB, 4'd15, 8'h88));
		append_instr(enc_rrr(cpu_pkg::OP_PCS, 4'd9, 4'd0, 4'd0));
		append_instr(enc_rrr(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
	endtask

	// loads and stores use r0 as base and branches only jump forward up to the HLT
	task automatic build_random_program(input int n);
		logic [31:0] r;
		logic [3:0]  op;
		prog_len = 0;
		for (int k = 0; k < n; k++) begin
			rng_state = xorshift32(rng_state);
			r = rng_state;
			op = r[3:0];
			if (op == cpu_pkg::OP_HLT) begin
				op = cpu_pkg::OP_LLB;
			end else if (op == cpu_pkg::OP_BR) begin
				op = cpu_pkg::OP_LHB;
			end
			case (op)
				cpu_pkg::OP_LW, cpu_pkg::OP_SW:
					append_instr(enc_rrr(op, r[7:4], 4'd0, r[15:12]));
				cpu_pkg::OP_LLB, cpu_pkg::OP_LHB:
					append_instr(enc_imm8(op, r[7:4], r[23:16]));
				cpu_pkg::OP_PCS:
					append_instr(enc_rrr(op, r[7:4], 4'd0, 4'd0));
				cpu_pkg::OP_B:
					append_instr(enc_branch(r[10:8], 9'(r[31:16] % (n - k))));
				default:
					append_instr(enc_rrr(op, r[7:4], r[11:8], r[15:12]));
			endcase
		end
		append_instr(enc_rrr(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0));
	endtask

	task automatic run_program(input string name);
		logic [15:0] hlt_addr;
		int          cycles;
		test_name = name;
		@(negedge clk);
		arst_n = 1'b0;
		for (int i = 0; i < prog_len; i++) begin
			imem_we    = 1'b1;
			imem_addr  = 8'(i);
			imem_wdata = prog[i];
			@(negedge clk);
		end
		imem_we = 1'b0;
		hlt_addr = run_model(prog_len);
		if (hlt_addr == 16'hffff) begin
			errors++;
			$display("%s: the reference model ran off the program without a HLT", name);
		end
		got = 0;
		repeat (2) @(negedge clk);
		arst_n = 1'b1;
		check_value("hlt_o after reset", 16'h0, hlt_o);
		check_value("wb_en_o after reset", 16'h0, wb_en_o);
		check_value("pc_o after reset", 16'h0, pc_o);
		cycles = 0;
		while (!hlt_o && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!hlt_o) begin
			errors++;
			$display("%s: hlt_o did not rise within %0d cycles", name, WAIT_LIMIT);
		end else begin
			check_value("pc_o at halt", hlt_addr, pc_o);
			repeat (20) @(negedge clk);
			check_value("hlt_o after halt", 16'h1, hlt_o);
			if (got != exp_reg.size()) begin
				errors++;
				$display("%s: saw %0d register writes where %0d were expected", name, got,
					exp_reg.size());
			end
		end
	endtask

	// every write-back is matched in order against the model's list
	always @(negedge clk) begin
		if (arst_n && wb_en_o) begin
			if (got < exp_reg.size()) begin
				check_value("wb_reg_o", exp_reg[got], wb_reg_o);
				check_value("wb_data_o", exp_data[got], wb_data_o);
				got++;
			end else begin
				errors++;
				$display("%s: unexpected write of %h to r%0d", test_name, wb_data_o, wb_reg_o);
			end
		end
	end

	initial begin
		arst_n     = 1'b0;
		imem_we    = 1'b0;
		imem_addr  = '0;
		imem_wdata = '0;
		errors     = 0;
		checks     = 0;
		got        = 0;
		prog_len   = 0;
		rng_state  = SEED;
		build_dmem_clear();
		run_program("dmem clear");
		build_alu_program();
		run_program("alu chain");
		build_load_store_program();
		run_program("load store");
		build_branch_program();
		run_program("branches");
		for (int p = 0; p < 20; p++) begin
			build_random_program(40);
			run_program($sformatf("random %0d", p));
		end
		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
